// File: verilog/accel_pkg.sv
package accel_pkg;

  // io bus
  localparam int io_addr_w = 8;
  localparam int io_data_w = 32;

  // one packet memory word is one stream beat
  localparam int beat_bytes = 4;

  // descriptor fields
  localparam int len_w       = 14;
  localparam int pmem_addr_w = 10;

  // unused bytes in the final beat of a packet
  typedef logic [1:0] empty_t;

  // io register map, byte offsets
  localparam logic [io_addr_w-1:0] reg_ctrl  = 8'h00;
  localparam logic [io_addr_w-1:0] reg_len   = 8'h04;
  localparam logic [io_addr_w-1:0] reg_addr  = 8'h08;
  localparam logic [io_addr_w-1:0] reg_hot   = 8'h0c;
  localparam logic [io_addr_w-1:0] reg_derr  = 8'h10;
  localparam logic [io_addr_w-1:0] reg_dnerr = 8'h14;
  localparam logic [io_addr_w-1:0] reg_first = 8'h20;

endpackage

// File: verilog/accel_if.sv
interface desc_if;
  import accel_pkg::*;

  logic [pmem_addr_w-1:0] addr;
  logic [len_w-1:0]       len;
  logic                   valid;
  logic                   stop;
  logic                   busy;
  logic                   error;

  modport ctrl (output addr, len, valid, stop, input busy, error);
  modport dma (input addr, len, valid, stop, output busy, error);
endinterface

interface stream_if;
  import accel_pkg::*;

  logic [beat_bytes*8-1:0] data;
  empty_t                  empty;
  logic                    last;
  logic                    valid;
  logic                    ready;

  modport source (output data, empty, last, valid, input ready);
  modport sink (input data, empty, last, valid, output ready);
endinterface

// File: verilog/accel_regs.sv
module accel_regs #(
  parameter int rule_count = 8,
  localparam int rule_w = $clog2(rule_count)
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [3:0]                      io_strb,
  input  logic [accel_pkg::io_addr_w-1:0] io_addr,
  input  logic [accel_pkg::io_data_w-1:0] io_wr_data,
  output logic [accel_pkg::io_data_w-1:0] io_rd_data,
  output logic                            io_rd_valid,
  desc_if.ctrl                            desc,
  input  logic                            hit,
  input  logic                            end_seen,
  input  logic [rule_w-1:0]               hit_rule,
  input  logic [accel_pkg::len_w-1:0]     hit_offset,
  input  logic [rule_count-1:0]           hit_hot
);
  import accel_pkg::*;

  logic                   wr_req;
  logic                   rd_req;
  logic                   ctrl_wr;
  logic                   start_cmd;
  logic                   stop_cmd;
  logic [len_w-1:0]       len_q;
  logic [pmem_addr_w-1:0] addr_q;
  logic                   done;
  logic                   match;
  logic                   done_err;
  logic [rule_count-1:0]  hot_q;
  logic [rule_w-1:0]      first_rule;
  logic [len_w-1:0]       first_off;
  logic                   scan_over;
  logic                   rd_stall;
  logic [io_data_w-1:0]   rd_word;

  assign wr_req    = io_en && io_wen;
  assign rd_req    = io_en && !io_wen;
  assign ctrl_wr   = wr_req && io_addr == reg_ctrl && io_strb[0];
  // stop wins if both bits are written together
  assign start_cmd = ctrl_wr && io_wr_data[0] && !io_wr_data[4];
  assign stop_cmd  = ctrl_wr && io_wr_data[4];
  assign scan_over = done || match;

  assign desc.len  = len_q;
  assign desc.addr = addr_q;

  always_ff @(posedge clk) begin
    desc.valid <= start_cmd;
    desc.stop  <= stop_cmd;
    if (wr_req && io_addr == reg_len) begin
      if (io_strb[0]) len_q[7:0] <= io_wr_data[7:0];
      if (io_strb[1]) len_q[len_w-1:8] <= io_wr_data[len_w-1:8];
    end
    if (wr_req && io_addr == reg_addr) begin
      if (io_strb[0]) addr_q[7:0] <= io_wr_data[7:0];
      if (io_strb[1]) addr_q[pmem_addr_w-1:8] <= io_wr_data[pmem_addr_w-1:8];
    end
    if (rst) begin
      desc.valid <= 1'b0;
      desc.stop  <= 1'b0;
    end
  end

  // status is cleared on the start write itself, so a read right after sees it low
  always_ff @(posedge clk) begin
    if (start_cmd) begin
      done       <= 1'b0;
      match      <= 1'b0;
      done_err   <= 1'b0;
      hot_q      <= '0;
      first_rule <= '0;
      first_off  <= '0;
    end else begin
      done     <= done || end_seen || desc.stop;
      match    <= match || hit;
      // stop while the DMA still moves data
      done_err <= done_err || (desc.stop && desc.busy);
      hot_q    <= hot_q | hit_hot;
      if (hit) begin
        first_rule <= hit_rule;
        first_off  <= hit_offset;
      end
    end
    if (rst) begin
      done       <= 1'b0;
      match      <= 1'b0;
      done_err   <= 1'b0;
      hot_q      <= '0;
      first_rule <= '0;
      first_off  <= '0;
    end
  end

  always_comb begin
    rd_word = '0;
    case (io_addr)
      reg_ctrl: begin
        rd_word[1] = desc.busy;
        rd_word[8] = done;
        rd_word[9] = match;
      end
      reg_len:   rd_word[len_w-1:0] = len_q;
      reg_addr:  rd_word[pmem_addr_w-1:0] = addr_q;
      reg_hot:   rd_word[rule_count-1:0] = hot_q;
      reg_derr:  rd_word[0] = desc.error;
      reg_dnerr: rd_word[0] = done_err;
      reg_first: begin
        rd_word[rule_w-1:0]  = first_rule;
        rd_word[16 +: len_w] = first_off;
      end
      default: ;
    endcase
  end

  // reg_hot holds off until the scan is over, host keeps the address
  always_ff @(posedge clk) begin
    io_rd_valid <= 1'b0;
    if (rd_stall) begin
      io_rd_data  <= rd_word;
      io_rd_valid <= scan_over;
      rd_stall    <= !scan_over;
    end else if (rd_req) begin
      io_rd_data  <= rd_word;
      io_rd_valid <= 1'b1;
      if (io_addr == reg_hot) begin
        io_rd_valid <= scan_over;
        rd_stall    <= !scan_over;
      end
    end
    if (rst) begin
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
    end
  end

endmodule

// File: verilog/pmem_rd_dma.sv
module pmem_rd_dma #(
  parameter int pmem_lines = 1024
) (
  input  logic                              clk,
  input  logic                              rst,
  desc_if.dma                               desc,
  output logic                              mem_rd_en,
  output logic [accel_pkg::pmem_addr_w-1:0] mem_rd_addr,
  input  logic [31:0]                       mem_rd_data,
  stream_if.source                          m
);
  import accel_pkg::*;

  logic                    busy;
  logic                    error;
  logic [pmem_addr_w-1:0]  rd_addr;
  logic [len_w-2:0]        words_left;
  empty_t                  tail_empty;
  logic                    inflight;
  logic                    inflight_last;
  logic [beat_bytes*8-1:0] buf_data [2];
  logic [1:0]              buf_last;
  logic                    wr_ptr;
  logic                    rd_ptr;
  logic [1:0]              count;
  logic [len_w:0]          len_plus;
  logic [len_w-2:0]        words;
  logic [len_w:0]          range_end;
  logic                    bad_desc;
  logic                    pop;
  logic [2:0]              occupancy;

  // byte length rounded up to whole words
  assign len_plus  = (len_w+1)'(desc.len) + (len_w+1)'(beat_bytes - 1);
  assign words     = len_plus[len_w:2];
  assign range_end = (len_w+1)'(desc.addr) + (len_w+1)'(words);
  assign bad_desc  = busy || desc.len == '0 || int'(range_end) > pmem_lines;

  // words buffered plus the one on its way back from memory
  assign pop       = m.valid && m.ready;
  assign occupancy = 3'(count) + 3'(inflight) - 3'(pop);
  assign mem_rd_en   = busy && words_left != '0 && occupancy < 3'd2;
  assign mem_rd_addr = rd_addr;

  assign m.valid = count != 2'd0;
  assign m.data  = buf_data[rd_ptr];
  assign m.last  = m.valid && buf_last[rd_ptr];
  assign m.empty = m.last ? tail_empty : '0;

  assign desc.busy  = busy;
  assign desc.error = error;

  always_ff @(posedge clk) begin
    inflight      <= mem_rd_en;
    inflight_last <= mem_rd_en && words_left == (len_w-1)'(1);
    if (desc.valid) begin
      error <= bad_desc;
      if (!bad_desc) begin
        busy       <= 1'b1;
        rd_addr    <= desc.addr;
        words_left <= words;
        tail_empty <= 2'd0 - desc.len[1:0];
      end
    end
    if (mem_rd_en) begin
      rd_addr    <= rd_addr + 1'b1;
      words_left <= words_left - 1'b1;
    end
    if (inflight) begin
      buf_data[wr_ptr] <= mem_rd_data;
      buf_last[wr_ptr] <= inflight_last;
      wr_ptr           <= !wr_ptr;
    end
    if (pop) rd_ptr <= !rd_ptr;
    count <= count + 2'(inflight) - 2'(pop);
    if (pop && m.last) busy <= 1'b0;
    // abort drops buffered words and the read still in flight
    if (desc.stop && busy) begin
      busy       <= 1'b0;
      words_left <= '0;
      inflight   <= 1'b0;
      count      <= 2'd0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
    end
    if (rst) begin
      busy       <= 1'b0;
      error      <= 1'b0;
      words_left <= '0;
      inflight   <= 1'b0;
      count      <= 2'd0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
    end
  end

endmodule

// File: verilog/pattern_scan.sv
module pattern_scan #(
  parameter int rule_count = 8,
  localparam int rule_w = $clog2(rule_count)
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rule_wr_en,
  input  logic [2:0]                  rule_wr_addr,
  input  logic [31:0]                 rule_wr_data,
  stream_if.sink                      s,
  output logic                        hit,
  output logic [rule_w-1:0]           hit_rule,
  output logic [accel_pkg::len_w-1:0] hit_offset,
  output logic [rule_count-1:0]       hit_hot,
  output logic                        end_seen
);
  import accel_pkg::*;

  localparam int pos_w = $clog2(beat_bytes);

  logic [31:0]              rules [rule_count];
  logic [rule_count-1:0]    rule_valid;
  logic [23:0]              hist;
  logic [len_w-1:0]         next_off;
  logic                     matched;
  logic                     accept;
  logic                     stage_valid;
  logic [beat_bytes*8+23:0] stage_win;
  empty_t                   stage_empty;
  logic                     stage_last;
  logic                     stage_first;
  logic [len_w-1:0]         stage_off;
  logic [beat_bytes-1:0]    win_ok;
  logic                     found;
  logic [rule_w-1:0]        best_rule;
  logic [pos_w-1:0]         best_pos;
  logic [rule_count-1:0]    hot;

  // the report side never stalls, so the stage drains every cycle
  assign s.ready = 1'b1;
  assign accept  = s.valid && s.ready;

  always_ff @(posedge clk) begin
    if (rule_wr_en && int'(rule_wr_addr) < rule_count) begin
      rules[rule_wr_addr[rule_w-1:0]]      <= rule_wr_data;
      rule_valid[rule_wr_addr[rule_w-1:0]] <= 1'b1;
    end
    if (rst) rule_valid <= '0;
  end

  // window j ends on beat byte j, earlier bytes come from the previous beat
  always_comb begin
    for (int j = 0; j < beat_bytes; j++) begin
      win_ok[j] = (j + int'(stage_empty) < beat_bytes) &&
                  (!stage_first || j == beat_bytes - 1);
    end
  end

  // earliest end position first, then the lowest rule
  always_comb begin
    found     = 1'b0;
    best_rule = '0;
    best_pos  = '0;
    hot       = '0;
    for (int j = 0; j < beat_bytes; j++) begin
      for (int r = 0; r < rule_count; r++) begin
        if (stage_valid && win_ok[j] && rule_valid[r] &&
            stage_win[j*8 +: 32] == rules[r]) begin
          hot[r] = 1'b1;
          if (!found) begin
            found     = 1'b1;
            best_rule = rule_w'(r);
            best_pos  = pos_w'(j);
          end
        end
      end
    end
  end

  assign hit        = found && !matched;
  assign hit_rule   = best_rule;
  assign hit_offset = stage_off + len_w'(best_pos);
  assign hit_hot    = hot;
  assign end_seen   = stage_valid && stage_last;

  always_ff @(posedge clk) begin
    stage_valid <= accept;
    if (accept) begin
      stage_win   <= {s.data, hist};
      hist        <= s.data[31:8];
      stage_empty <= s.empty;
      stage_last  <= s.last;
      stage_first <= next_off == '0;
      stage_off   <= next_off;
      next_off    <= s.last ? '0 : next_off + len_w'(beat_bytes);
    end
    // only the first match of a packet is reported
    if (stage_valid) matched <= !stage_last && (matched || found);
    if (rst) begin
      stage_valid <= 1'b0;
      next_off    <= '0;
      matched     <= 1'b0;
    end
  end

endmodule

// File: verilog/accel_wrap.sv
module accel_wrap #(
  parameter int rule_count = 8,
  parameter int pmem_lines = 1024
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              io_en,
  input  logic                              io_wen,
  input  logic [3:0]                        io_strb,
  input  logic [accel_pkg::io_addr_w-1:0]   io_addr,
  input  logic [accel_pkg::io_data_w-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_w-1:0]   io_rd_data,
  output logic                              io_rd_valid,
  input  logic                              rule_wr_en,
  input  logic [2:0]                        rule_wr_addr,
  input  logic [31:0]                       rule_wr_data,
  output logic                              mem_rd_en,
  output logic [accel_pkg::pmem_addr_w-1:0] mem_rd_addr,
  input  logic [31:0]                       mem_rd_data
);
  import accel_pkg::*;

  localparam int rule_w = $clog2(rule_count);

  logic                  scan_hit;
  logic                  scan_end;
  logic [rule_w-1:0]     scan_rule;
  logic [len_w-1:0]      scan_offset;
  logic [rule_count-1:0] scan_hot;

  desc_if   u_desc_if ();
  stream_if u_stream_if ();

  accel_regs #(
    .rule_count (rule_count)
  ) u_regs (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .desc        (u_desc_if.ctrl),
    .hit         (scan_hit),
    .end_seen    (scan_end),
    .hit_rule    (scan_rule),
    .hit_offset  (scan_offset),
    .hit_hot     (scan_hot)
  );

  pmem_rd_dma #(
    .pmem_lines (pmem_lines)
  ) u_dma (
    .clk         (clk),
    .rst         (rst),
    .desc        (u_desc_if.dma),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data),
    .m           (u_stream_if.source)
  );

  pattern_scan #(
    .rule_count (rule_count)
  ) u_scan (
    .clk          (clk),
    .rst          (rst),
    .rule_wr_en   (rule_wr_en),
    .rule_wr_addr (rule_wr_addr),
    .rule_wr_data (rule_wr_data),
    .s            (u_stream_if.sink),
    .hit          (scan_hit),
    .hit_rule     (scan_rule),
    .hit_offset   (scan_offset),
    .hit_hot      (scan_hot),
    .end_seen     (scan_end)
  );

endmodule

// File: bench/accel_sva.sv
module accel_sva (
  input logic                            clk,
  input logic                            rst,
  input logic                            io_en,
  input logic                            io_wen,
  input logic [accel_pkg::io_addr_w-1:0] io_addr,
  input logic                            io_rd_valid,
  input logic                            rd_stall,
  input logic                            desc_valid,
  input logic                            desc_stop,
  input logic                            done,
  input logic                            match,
  input logic                            hot_any
);
  timeunit 1ns;
  timeprecision 1ps;
  import accel_pkg::*;

  // every register except reg_hot answers in the next cycle
  a_rd_latency: assert property (@(posedge clk) disable iff (rst)
    io_en && !io_wen && !rd_stall && io_addr != reg_hot |=> io_rd_valid)
    else $error("io_rd_valid missing one cycle after a register read");

  // the DMA never sees a start and a stop in one cycle
  a_no_start_stop: assert property (@(posedge clk) disable iff (rst)
    !(desc_valid && desc_stop))
    else $error("desc valid and stop issued in the same cycle");

  a_reset_idle: assert property (@(posedge clk)
    $past(rst) |-> !io_rd_valid && !rd_stall && !done && !match && !hot_any)
    else $error("register block not idle in the cycle after reset");

endmodule

bind accel_regs accel_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .io_en       (io_en),
  .io_wen      (io_wen),
  .io_addr     (io_addr),
  .io_rd_valid (io_rd_valid),
  .rd_stall    (rd_stall),
  .desc_valid  (desc.valid),
  .desc_stop   (desc.stop),
  .done        (done),
  .match       (match),
  .hot_any     (|hot_q)
);

// File: bench/accel_tb.sv
module accel_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import accel_pkg::*;

  localparam int rule_count = 8;
  localparam int pmem_lines = 1024;
  localparam int gold_words = 512;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   io_en;
  logic                   io_wen;
  logic [3:0]             io_strb;
  logic [io_addr_w-1:0]   io_addr;
  logic [io_data_w-1:0]   io_wr_data;
  logic [io_data_w-1:0]   io_rd_data;
  logic                   io_rd_valid;
  logic                   rule_wr_en;
  logic [2:0]             rule_wr_addr;
  logic [31:0]            rule_wr_data;
  logic                   mem_rd_en;
  logic [pmem_addr_w-1:0] mem_rd_addr;
  logic [31:0]            mem_rd_data;

  logic [31:0]            pmem [pmem_lines];
  logic [31:0]            gold [gold_words];
  logic                   rd_pending = 1'b0;
  logic [pmem_addr_w-1:0] rd_pend_addr;
  logic [31:0]            rng = 32'h1327;
  int                     cycles = 0;
  int                     limit = 0;
  int                     errors = 0;
  int                     test_errs = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  int                     checks = 0;

  always #50 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  accel_wrap #(
    .rule_count (rule_count),
    .pmem_lines (pmem_lines)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .rule_wr_en   (rule_wr_en),
    .rule_wr_addr (rule_wr_addr),
    .rule_wr_data (rule_wr_data),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_addr  (mem_rd_addr),
    .mem_rd_data  (mem_rd_data)
  );

  // packet memory, the word arrives in the cycle after the read
  always @(negedge clk) begin
    if (rd_pending) mem_rd_data = pmem[rd_pend_addr];
    rd_pending   = mem_rd_en;
    rd_pend_addr = mem_rd_addr;
  end

  // byte 1 of every word stays below 4, so no rule can match the fill
  function automatic logic [31:0] fill_word(input int a);
    logic [pmem_addr_w-1:0] w;
    w = pmem_addr_w'(a);
    return {16'hf0f0 ^ 16'(w), 6'h00, w};
  endfunction

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // words per test plus a margin, four cycles each
  function automatic int size_limit();
    int p;
    int total;
    p = 0;
    total = 0;
    while (p < gold_words && gold[p] !== 32'h0) begin
      case (gold[p])
        32'h3: begin
          total += (int'((gold[p+2] + 3) / 4) + 40) * 4;
          p += 11;
        end
        32'h4: begin
          total += 40 * 4;
          p += 3;
        end
        default: p += 3;
      endcase
    end
    return total;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic note_error(input string what);
    $display("error at t=%0t: %s", $time, what);
    errors++;
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, test_errs == 0 ? "ok" : "failed");
  endtask

  task automatic write_rule(input logic [31:0] idx, input logic [31:0] data);
    @(negedge clk);
    rule_wr_en   = 1'b1;
    rule_wr_addr = idx[2:0];
    rule_wr_data = data;
    @(negedge clk);
    rule_wr_en = 1'b0;
  endtask

  task automatic write_reg(input logic [io_addr_w-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = 4'hf;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // address is held until io_rd_valid, a reg_hot read may stall
  task automatic read_reg(input logic [io_addr_w-1:0] addr, output logic [31:0] data,
                          output int lat);
    @(negedge clk);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    lat     = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!io_rd_valid);
    data  = io_rd_data;
    io_en = 1'b0;
    if (addr != reg_hot && lat != 1) begin
      note_error($sformatf("read of 0x%0h answered after %0d cycles", addr, lat));
    end
  endtask

  task automatic wait_bit(input logic [io_addr_w-1:0] addr, input int idx);
    logic [31:0] d;
    int          lat;
    do begin
      repeat (next_rand() % 4) @(negedge clk);
      read_reg(addr, d, lat);
    end while (!d[idx]);
  endtask

  task automatic run_regs(input logic [31:0] len, input logic [31:0] addr);
    logic [31:0] d;
    int          lat;
    test_errs = 0;
    write_reg(reg_len, len);
    write_reg(reg_addr, addr);
    read_reg(reg_len, d, lat);
    compare("reg_len", d, len);
    read_reg(reg_addr, d, lat);
    compare("reg_addr", d, addr);
    finish_test("register read-back");
  endtask

  task automatic run_scan(input int p);
    logic [31:0] a;
    logic [31:0] len;
    logic [31:0] mode;
    logic [31:0] d;
    int          lat;
    a         = gold[p+1];
    len       = gold[p+2];
    mode      = gold[p+3];
    test_errs = 0;
    write_reg(reg_addr, a);
    write_reg(reg_len, len);
    write_reg(reg_ctrl, 32'h1);
    if (mode == 32'h2) begin
      read_reg(reg_hot, d, lat);
      if (lat < 2) note_error("reg_hot read returned before the scan was over");
      compare("reg_hot stalled", d, gold[p+8]);
    end
    if (mode == 32'h1) begin
      repeat (2 + next_rand() % 8) @(negedge clk);
      write_reg(reg_ctrl, 32'h10);
    end
    // a rejected descriptor never finishes, so watch the error flag instead
    if (gold[p+9] != 32'h0) begin
      wait_bit(reg_derr, 0);
    end else begin
      wait_bit(reg_ctrl, 8);
    end
    read_reg(reg_ctrl, d, lat);
    compare("ctrl busy", 32'(d[1]), 32'h0);
    compare("ctrl done", 32'(d[8]), gold[p+4]);
    compare("ctrl match", 32'(d[9]), gold[p+5]);
    if (gold[p+4] != 32'h0 || gold[p+5] != 32'h0) begin
      read_reg(reg_first, d, lat);
      compare("first rule", 32'(d[7:0]), gold[p+6]);
      compare("first offset", 32'(d[29:16]), gold[p+7]);
      read_reg(reg_hot, d, lat);
      compare("reg_hot", d, gold[p+8]);
    end
    read_reg(reg_derr, d, lat);
    compare("reg_derr", d, gold[p+9]);
    read_reg(reg_dnerr, d, lat);
    compare("reg_dnerr", d, gold[p+10]);
    finish_test($sformatf("scan addr 0x%0h len %0d mode %0d", a, len, mode));
  endtask

  initial begin
    wait (limit != 0);
    while (cycles < limit) @(posedge clk);
    $display("timeout: no result after %0d cycles", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int p;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = 4'h0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr_en   = 1'b0;
    rule_wr_addr = 3'd0;
    rule_wr_data = 32'h0;
    mem_rd_data  = 32'h0;
    for (int i = 0; i < pmem_lines; i++) pmem[i] = fill_word(i);
    $readmemh("bench/accel_golden.txt", gold);
    limit = size_limit();
    repeat (8) @(negedge clk);
    rst = 1'b0;

    p = 0;
    while (p < gold_words && gold[p] !== 32'h0) begin
      case (gold[p])
        32'h1: begin
          write_rule(gold[p+1], gold[p+2]);
          p += 3;
        end
        32'h2: begin
          pmem[gold[p+1][pmem_addr_w-1:0]] = gold[p+2];
          p += 3;
        end
        32'h3: begin
          run_scan(p);
          p += 11;
        end
        32'h4: begin
          run_regs(gold[p+1], gold[p+2]);
          p += 3;
        end
        default: begin
          note_error($sformatf("unknown record 0x%0h in the golden file", gold[p]));
          p = gold_words;
        end
      endcase
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_run != 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: bench/accel_golden.txt
// op 1: rule index, rule word with the first pattern byte in bits 7:0
// op 2: memory word address, data word with the first packet byte in bits 7:0
// op 4: len and addr values written and read back
// op 3: addr len mode done match rule offset hot derr dnerr (mode 0 poll, 1 stop, 2 reg_hot stall)
// op 0: end of records
1 0 44434241
1 1 46454443
1 2 5a595857
1 3 54535251
1 4 706f6e6d
1 5 5251504f
// QRST ends at byte 5
2 3e0 52511211
2 3e1 14135453
2 3e2 18171615
// OPQR crosses the first beat boundary, QRST and ABCD end later
2 3e8 504f0201
2 3e9 54535251
2 3ea 44434241
// six bytes, mnop sits in the unused tail
2 3f0 04030201
2 3f1 706f6e6d
4 1abc 2d3
3 3e0 c 0 1 1 3 5 8 0 0
3 3e8 c 0 1 1 5 5 29 0 0
3 3f0 6 0 1 0 0 0 0 0 0
3 3e0 0 0 0 0 0 0 0 1 0
3 3fc 18 0 0 0 0 0 0 1 0
3 3e0 c 2 1 1 3 5 8 0 0
3 0 c00 1 1 0 0 0 0 0 1
0

// File: src.f
verilog/accel_pkg.sv
verilog/accel_if.sv
verilog/accel_regs.sv
verilog/pmem_rd_dma.sv
verilog/pattern_scan.sv
verilog/accel_wrap.sv
bench/accel_sva.sv
bench/accel_tb.sv

// File: Makefile
SRCS := $(shell cat src.f)

obj_dir/Vaccel_tb: src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  --top-module accel_tb -f src.f

run: obj_dir/Vaccel_tb
	./obj_dir/Vaccel_tb | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
